//--- rtl/ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Datapath and structure sizes
`define OOO_WORD_W 16
`define OOO_NUM_REGS 8
`define OOO_ROB_DEPTH 8
`define OOO_RS_COUNT 3

// LC-3b opcode field values
`define OOO_OP_ADD 4'd1
`define OOO_OP_AND 4'd5
`define OOO_OP_NOT 4'd9

`endif

//--- rtl/ooo_pkg.sv
`include "ooo_defs.svh"

package ooo_pkg;

	typedef logic [`OOO_WORD_W-1:0] word_t;
	typedef logic [15:0] instr_t;

	// Architectural register number
	typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

	// ROB slot, also used as the rename tag
	typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

	typedef logic [3:0] opcode_t;
	typedef logic [$clog2(`OOO_RS_COUNT)-1:0] rs_id_t;

endpackage

//--- rtl/regfile.sv
`include "ooo_defs.svh"

module regfile (
	input logic clk,
	input logic reset,
	input ooo_pkg::reg_idx_t sr1,
	input ooo_pkg::reg_idx_t sr2,
	input ooo_pkg::reg_idx_t dest,
	input logic rename_we,
	input ooo_pkg::rob_tag_t alloc_tag,
	input logic commit_valid,
	input ooo_pkg::reg_idx_t commit_dest,
	input ooo_pkg::rob_tag_t commit_tag,
	input ooo_pkg::word_t commit_value,
	output ooo_pkg::word_t sr1_value,
	output ooo_pkg::word_t sr2_value,
	output logic sr1_busy,
	output logic sr2_busy,
	output ooo_pkg::rob_tag_t sr1_tag,
	output ooo_pkg::rob_tag_t sr2_tag
);
	import ooo_pkg::*;

	word_t reg_value [`OOO_NUM_REGS];
	logic [`OOO_NUM_REGS-1:0] reg_busy;
	rob_tag_t reg_tag [`OOO_NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `OOO_NUM_REGS; i++)
			begin
				reg_value[i] <= '0;
				reg_busy[i] <= 1'b0;
				reg_tag[i] <= '0;
			end
		end
		else
		begin
			if (commit_valid)
			begin
				reg_value[commit_dest] <= commit_value;
				// A younger rename keeps the register pending
				if (reg_tag[commit_dest] == commit_tag)
					reg_busy[commit_dest] <= 1'b0;
			end
			// Placed last so rename wins over a commit to the same register
			if (rename_we)
			begin
				reg_busy[dest] <= 1'b1;
				reg_tag[dest] <= alloc_tag;
			end
		end
	end

	assign sr1_value = reg_value[sr1];
	assign sr2_value = reg_value[sr2];
	assign sr1_busy = reg_busy[sr1];
	assign sr2_busy = reg_busy[sr2];
	assign sr1_tag = reg_tag[sr1];
	assign sr2_tag = reg_tag[sr2];

endmodule

//--- rtl/reorder_buffer.sv
`include "ooo_defs.svh"

module reorder_buffer (
	input logic clk,
	input logic reset,
	input logic rob_alloc,
	input ooo_pkg::reg_idx_t alloc_dest,
	input logic cdb_valid,
	input ooo_pkg::rob_tag_t cdb_tag,
	input ooo_pkg::word_t cdb_value,
	input ooo_pkg::rob_tag_t sr1_tag,
	input ooo_pkg::rob_tag_t sr2_tag,
	output logic sr1_done,
	output logic sr2_done,
	output ooo_pkg::word_t sr1_value,
	output ooo_pkg::word_t sr2_value,
	output ooo_pkg::rob_tag_t rob_tail,
	output logic rob_full,
	output logic commit_valid,
	output ooo_pkg::reg_idx_t commit_dest,
	output ooo_pkg::word_t commit_value,
	output ooo_pkg::rob_tag_t commit_tag
);
	import ooo_pkg::*;

	localparam int COUNT_W = $clog2(`OOO_ROB_DEPTH + 1);

	reg_idx_t entry_dest [`OOO_ROB_DEPTH];
	word_t entry_value [`OOO_ROB_DEPTH];
	logic [`OOO_ROB_DEPTH-1:0] entry_done;
	rob_tag_t head;
	logic [COUNT_W-1:0] count;

	// Wraps correctly for depths that are not a power of two
	function automatic rob_tag_t next_tag(input rob_tag_t tag);
		if (tag == rob_tag_t'(`OOO_ROB_DEPTH - 1))
			return '0;
		return tag + 1'b1;
	endfunction

	assign rob_full = (count == COUNT_W'(`OOO_ROB_DEPTH));

	// Head retires as soon as its result has been written back
	assign commit_valid = (count != '0) && entry_done[head];
	assign commit_dest = entry_dest[head];
	assign commit_value = entry_value[head];
	assign commit_tag = head;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			head <= '0;
			rob_tail <= '0;
			count <= '0;
			entry_done <= '0;
		end
		else
		begin
			if (cdb_valid)
				entry_done[cdb_tag] <= 1'b1;
			if (rob_alloc)
			begin
				entry_done[rob_tail] <= 1'b0;
				rob_tail <= next_tag(rob_tail);
			end
			if (commit_valid)
				head <= next_tag(head);
			count <= count + COUNT_W'(rob_alloc) - COUNT_W'(commit_valid);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rob_alloc)
			entry_dest[rob_tail] <= alloc_dest;
		if (cdb_valid)
			entry_value[cdb_tag] <= cdb_value;
	end

	// Source lookups for renamed operands
	assign sr1_done = entry_done[sr1_tag];
	assign sr2_done = entry_done[sr2_tag];
	assign sr1_value = entry_value[sr1_tag];
	assign sr2_value = entry_value[sr2_tag];

endmodule

//--- rtl/alu_rs_unit.sv
`include "ooo_defs.svh"

module alu_rs_unit (
	input logic clk,
	input logic reset,
	input logic rs_alloc,
	input ooo_pkg::opcode_t rs_op,
	input ooo_pkg::word_t vj,
	input ooo_pkg::word_t vk,
	input logic vj_ok,
	input logic vk_ok,
	input ooo_pkg::rob_tag_t qj,
	input ooo_pkg::rob_tag_t qk,
	input ooo_pkg::rob_tag_t rs_dest,
	output logic rs_free,
	output logic cdb_valid,
	output ooo_pkg::rob_tag_t cdb_tag,
	output ooo_pkg::word_t cdb_value
);
	import ooo_pkg::*;

	opcode_t st_op [`OOO_RS_COUNT];
	word_t st_vj [`OOO_RS_COUNT];
	word_t st_vk [`OOO_RS_COUNT];
	rob_tag_t st_qj [`OOO_RS_COUNT];
	rob_tag_t st_qk [`OOO_RS_COUNT];
	rob_tag_t st_dest [`OOO_RS_COUNT];
	logic [`OOO_RS_COUNT-1:0] st_busy;
	logic [`OOO_RS_COUNT-1:0] st_vj_ok;
	logic [`OOO_RS_COUNT-1:0] st_vk_ok;
	logic [`OOO_RS_COUNT-1:0] st_ready;
	logic [`OOO_RS_COUNT-1:0] snoop_j;
	logic [`OOO_RS_COUNT-1:0] snoop_k;
	rs_id_t alloc_id;
	rs_id_t issue_id;
	logic issue_go;
	word_t alu_result;

	assign rs_free = ~&st_busy;
	assign st_ready = st_busy & st_vj_ok & st_vk_ok;
	assign issue_go = |st_ready;

	// Lowest idle slot for allocation, lowest ready slot for dispatch
	always_comb
	begin
		alloc_id = '0;
		issue_id = '0;
		for (int i = `OOO_RS_COUNT - 1; i >= 0; i--)
		begin
			if (!st_busy[i])
				alloc_id = rs_id_t'(i);
			if (st_ready[i])
				issue_id = rs_id_t'(i);
		end
	end

	// Waiting operands watch the bus, our own broadcast included
	always_comb
	begin
		for (int i = 0; i < `OOO_RS_COUNT; i++)
		begin
			snoop_j[i] = cdb_valid && st_busy[i] && !st_vj_ok[i] && (st_qj[i] == cdb_tag);
			snoop_k[i] = cdb_valid && st_busy[i] && !st_vk_ok[i] && (st_qk[i] == cdb_tag);
		end
	end

	always_comb
	begin
		case (st_op[issue_id])
			`OOO_OP_ADD: alu_result = st_vj[issue_id] + st_vk[issue_id];
			`OOO_OP_AND: alu_result = st_vj[issue_id] & st_vk[issue_id];
			// NOT comes with an all-ones second operand
			`OOO_OP_NOT: alu_result = st_vj[issue_id] ^ st_vk[issue_id];
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			st_busy <= '0;
			st_vj_ok <= '0;
			st_vk_ok <= '0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			st_vj_ok <= st_vj_ok | snoop_j;
			st_vk_ok <= st_vk_ok | snoop_k;
			if (rs_alloc)
			begin
				st_busy[alloc_id] <= 1'b1;
				st_vj_ok[alloc_id] <= vj_ok;
				st_vk_ok[alloc_id] <= vk_ok;
			end
			if (issue_go)
				st_busy[issue_id] <= 1'b0;
			cdb_valid <= issue_go;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `OOO_RS_COUNT; i++)
		begin
			if (snoop_j[i])
				st_vj[i] <= cdb_value;
			if (snoop_k[i])
				st_vk[i] <= cdb_value;
		end
		if (rs_alloc)
		begin
			st_op[alloc_id] <= rs_op;
			st_vj[alloc_id] <= vj;
			st_vk[alloc_id] <= vk;
			st_qj[alloc_id] <= qj;
			st_qk[alloc_id] <= qk;
			st_dest[alloc_id] <= rs_dest;
		end
		if (issue_go)
		begin
			cdb_tag <= st_dest[issue_id];
			cdb_value <= alu_result;
		end
	end

endmodule

//--- rtl/issue_control.sv
`include "ooo_defs.svh"

module issue_control (
	input ooo_pkg::instr_t instr,
	input logic instr_valid,
	input ooo_pkg::word_t rf_sr1_value,
	input ooo_pkg::word_t rf_sr2_value,
	input logic rf_sr1_busy,
	input logic rf_sr2_busy,
	input ooo_pkg::rob_tag_t rf_sr1_tag,
	input ooo_pkg::rob_tag_t rf_sr2_tag,
	input logic rob_sr1_done,
	input logic rob_sr2_done,
	input ooo_pkg::word_t rob_sr1_value,
	input ooo_pkg::word_t rob_sr2_value,
	input logic cdb_valid,
	input ooo_pkg::rob_tag_t cdb_tag,
	input ooo_pkg::word_t cdb_value,
	input logic rob_full,
	input logic rs_free,
	input ooo_pkg::rob_tag_t rob_tail,
	output ooo_pkg::reg_idx_t sr1,
	output ooo_pkg::reg_idx_t sr2,
	output ooo_pkg::reg_idx_t dest,
	output ooo_pkg::rob_tag_t sr1_tag,
	output ooo_pkg::rob_tag_t sr2_tag,
	output logic rename_we,
	output logic rob_alloc,
	output logic rs_alloc,
	output ooo_pkg::opcode_t rs_op,
	output ooo_pkg::word_t vj,
	output ooo_pkg::word_t vk,
	output logic vj_ok,
	output logic vk_ok,
	output ooo_pkg::rob_tag_t qj,
	output ooo_pkg::rob_tag_t qk,
	output ooo_pkg::rob_tag_t rs_dest,
	output logic stall
);
	import ooo_pkg::*;

	word_t imm_value;
	logic issue_fire;

	// LC-3b field layout
	assign rs_op = instr[15:12];
	assign dest = instr[11:9];
	assign sr1 = instr[8:6];
	assign sr2 = instr[2:0];
	assign imm_value = {{(`OOO_WORD_W - 5){instr[4]}}, instr[4:0]};

	// The ROB reads the entries the register file points at
	assign sr1_tag = rf_sr1_tag;
	assign sr2_tag = rf_sr2_tag;

	// Operand priority is register file, then ROB, then the live bus
	always_comb
	begin
		vj = rf_sr1_value;
		vj_ok = 1'b1;
		qj = rf_sr1_tag;
		if (rf_sr1_busy)
		begin
			if (rob_sr1_done)
				vj = rob_sr1_value;
			else if (cdb_valid && cdb_tag == rf_sr1_tag)
				vj = cdb_value;
			else
				vj_ok = 1'b0;
		end
	end

	always_comb
	begin
		vk = rf_sr2_value;
		vk_ok = 1'b1;
		qk = rf_sr2_tag;
		if (rs_op == `OOO_OP_NOT)
			vk = '1;
		else if (instr[5])
			vk = imm_value;
		else if (rf_sr2_busy)
		begin
			if (rob_sr2_done)
				vk = rob_sr2_value;
			else if (cdb_valid && cdb_tag == rf_sr2_tag)
				vk = cdb_value;
			else
				vk_ok = 1'b0;
		end
	end

	assign stall = rob_full | ~rs_free;
	assign issue_fire = instr_valid & ~stall;

	// One strobe per structure, all raised together
	assign rename_we = issue_fire;
	assign rob_alloc = issue_fire;
	assign rs_alloc = issue_fire;
	assign rs_dest = rob_tail;

endmodule

//--- rtl/ooo_core.sv
module ooo_core (
	input logic clk,
	input logic reset,
	input ooo_pkg::instr_t instr,
	input logic instr_valid,
	output logic stall,
	output logic commit_valid,
	output ooo_pkg::reg_idx_t commit_dest,
	output ooo_pkg::word_t commit_value
);
	import ooo_pkg::*;

	// Issue to register file and ROB
	reg_idx_t sr1;
	reg_idx_t sr2;
	reg_idx_t dest;
	rob_tag_t sr1_tag;
	rob_tag_t sr2_tag;
	logic rename_we;
	logic rob_alloc;

	// Lookup responses
	word_t rf_sr1_value;
	word_t rf_sr2_value;
	logic rf_sr1_busy;
	logic rf_sr2_busy;
	rob_tag_t rf_sr1_tag;
	rob_tag_t rf_sr2_tag;
	logic rob_sr1_done;
	logic rob_sr2_done;
	word_t rob_sr1_value;
	word_t rob_sr2_value;
	rob_tag_t rob_tail;
	logic rob_full;

	// Issue to stations
	logic rs_alloc;
	opcode_t rs_op;
	word_t vj;
	word_t vk;
	logic vj_ok;
	logic vk_ok;
	rob_tag_t qj;
	rob_tag_t qk;
	rob_tag_t rs_dest;
	logic rs_free;

	// Common data bus and commit
	logic cdb_valid;
	rob_tag_t cdb_tag;
	word_t cdb_value;
	rob_tag_t commit_tag;

	issue_control issue_i (
		.instr, .instr_valid,
		.rf_sr1_value, .rf_sr2_value, .rf_sr1_busy, .rf_sr2_busy,
		.rf_sr1_tag, .rf_sr2_tag,
		.rob_sr1_done, .rob_sr2_done, .rob_sr1_value, .rob_sr2_value,
		.cdb_valid, .cdb_tag, .cdb_value,
		.rob_full, .rs_free, .rob_tail,
		.sr1, .sr2, .dest, .sr1_tag, .sr2_tag,
		.rename_we, .rob_alloc, .rs_alloc,
		.rs_op, .vj, .vk, .vj_ok, .vk_ok, .qj, .qk, .rs_dest,
		.stall
	);

	regfile regfile_i (
		.clk, .reset,
		.sr1, .sr2, .dest,
		.rename_we, .alloc_tag(rob_tail),
		.commit_valid, .commit_dest, .commit_tag, .commit_value,
		.sr1_value(rf_sr1_value), .sr2_value(rf_sr2_value),
		.sr1_busy(rf_sr1_busy), .sr2_busy(rf_sr2_busy),
		.sr1_tag(rf_sr1_tag), .sr2_tag(rf_sr2_tag)
	);

	reorder_buffer rob_i (
		.clk, .reset,
		.rob_alloc, .alloc_dest(dest),
		.cdb_valid, .cdb_tag, .cdb_value,
		.sr1_tag, .sr2_tag,
		.sr1_done(rob_sr1_done), .sr2_done(rob_sr2_done),
		.sr1_value(rob_sr1_value), .sr2_value(rob_sr2_value),
		.rob_tail, .rob_full,
		.commit_valid, .commit_dest, .commit_value, .commit_tag
	);

	alu_rs_unit rs_i (
		.clk, .reset,
		.rs_alloc, .rs_op, .vj, .vk, .vj_ok, .vk_ok, .qj, .qk, .rs_dest,
		.rs_free,
		.cdb_valid, .cdb_tag, .cdb_value
	);

endmodule

//--- tests/ooo_core_sva.sv
`include "ooo_defs.svh"

module ooo_core_sva (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic [$clog2(`OOO_ROB_DEPTH + 1)-1:0] rob_count,
	input logic [`OOO_RS_COUNT-1:0] st_busy,
	input logic cdb_valid,
	input ooo_pkg::rob_tag_t cdb_tag,
	input logic commit_valid,
	input ooo_pkg::reg_idx_t commit_dest
);

	// Nothing retires straight out of reset
	commit_after_reset: assert property (@(posedge clk) reset |=> !commit_valid)
		else $error("commit_valid high in the cycle after reset");

	// Room judged from the ROB occupancy and the station busy bits
	stall_with_room: assert property (@(posedge clk) disable iff (reset)
		(rob_count < `OOO_ROB_DEPTH && !(&st_busy)) |-> !stall)
		else $error("stall raised while ROB and stations had room");

	// Each tag is broadcast once
	cdb_single_pulse: assert property (@(posedge clk) disable iff (reset)
		cdb_valid |=> !(cdb_valid && cdb_tag == $past(cdb_tag)))
		else $error("cdb_valid held for the same tag");

	commit_dest_known: assert property (@(posedge clk) disable iff (reset)
		commit_valid |-> !$isunknown(commit_dest))
		else $error("commit_dest unknown during commit");

endmodule

bind ooo_core ooo_core_sva sva_i (
	.clk, .reset, .stall,
	.rob_count(rob_i.count), .st_busy(rs_i.st_busy),
	.cdb_valid, .cdb_tag, .commit_valid, .commit_dest
);

//--- tests/ooo_core_tb.sv
`include "ooo_defs.svh"

module ooo_core_tb;
	import ooo_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	// Instructions issued by all tests together
	localparam int TOTAL_INSTRS = 64;

	logic clk;
	logic reset;
	instr_t instr;
	logic instr_valid;
	logic stall;
	logic commit_valid;
	reg_idx_t commit_dest;
	word_t commit_value;

	// Architectural state as seen in program order
	word_t ref_regs [`OOO_NUM_REGS];
	word_t exp_value [$];
	reg_idx_t exp_dest [$];
	int commit_count;
	int seed;

	ooo_core dut_i (
		.clk, .reset, .instr, .instr_valid,
		.stall, .commit_valid, .commit_dest, .commit_value
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s is R%0d, expected R%0d",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	function automatic instr_t imm_instr(input opcode_t op, input reg_idx_t dr,
		input reg_idx_t sr, input logic [4:0] imm);
		return {op, dr, sr, 1'b1, imm};
	endfunction

	function automatic instr_t reg_instr(input opcode_t op, input reg_idx_t dr,
		input reg_idx_t sr1, input reg_idx_t sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic instr_t not_instr(input reg_idx_t dr, input reg_idx_t sr);
		return {`OOO_OP_NOT, dr, sr, 6'b111111};
	endfunction

	// LC-3b semantics on the reference registers
	function automatic word_t model_result(input instr_t ins);
		word_t a;
		word_t b;
		a = ref_regs[ins[8:6]];
		if (ins[5])
			b = {{(`OOO_WORD_W - 5){ins[4]}}, ins[4:0]};
		else
			b = ref_regs[ins[2:0]];
		case (ins[15:12])
			`OOO_OP_ADD: return a + b;
			`OOO_OP_AND: return a & b;
			default: return ~a;
		endcase
	endfunction

	function automatic instr_t random_instr();
		int r;
		opcode_t op;
		r = $random(seed);
		op = (r[17:16] == 2'd1) ? `OOO_OP_AND : `OOO_OP_ADD;
		if (r[17:16] == 2'd2)
			return not_instr(r[11:9], r[8:6]);
		if (r[5])
			return imm_instr(op, r[11:9], r[8:6], r[4:0]);
		return reg_instr(op, r[11:9], r[8:6], r[2:0]);
	endfunction

	// Holds the word until the core accepts it
	task automatic issue_instr(input instr_t ins);
		word_t result;
		instr = ins;
		instr_valid = 1'b1;
		while (stall)
			@(negedge clk);
		result = model_result(ins);
		exp_value.push_back(result);
		exp_dest.push_back(ins[11:9]);
		ref_regs[ins[11:9]] = result;
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	task automatic wait_for_commits();
		while (exp_value.size() != 0)
			@(negedge clk);
	endtask

	// Every commit is compared against the oldest outstanding instruction
	always @(negedge clk)
	begin
		if (!reset && commit_valid)
		begin
			if (exp_value.size() == 0)
				abort_run("A commit appeared with no instruction outstanding");
			else
			begin
				check_reg("commit_dest", commit_dest, exp_dest.pop_front());
				check_word("commit_value", commit_value, exp_value.pop_front());
				commit_count++;
			end
		end
	end

	task automatic test_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge clk);
			check_flag("commit_valid after reset", commit_valid, 1'b0);
			check_flag("stall after reset", stall, 1'b0);
		end
	endtask

	task automatic test_immediate();
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd1, 3'd0, 5'd5));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd2, 3'd0, 5'b11101));
		issue_instr(imm_instr(`OOO_OP_AND, 3'd3, 3'd0, 5'd7));
		issue_instr(not_instr(3'd4, 3'd0));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd5, 3'd0, 5'd15));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd6, 3'd0, 5'b10000));
		issue_instr(imm_instr(`OOO_OP_AND, 3'd7, 3'd0, 5'b11111));
		wait_for_commits();
	endtask

	// Chains that lean on renaming and bus forwarding
	task automatic test_dependencies();
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd1, 3'd0, 5'd9));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd2, 3'd1, 5'd3));
		issue_instr(reg_instr(`OOO_OP_ADD, 3'd3, 3'd1, 3'd2));
		issue_instr(reg_instr(`OOO_OP_AND, 3'd4, 3'd3, 3'd2));
		issue_instr(not_instr(3'd5, 3'd4));
		issue_instr(reg_instr(`OOO_OP_ADD, 3'd6, 3'd5, 3'd3));
		issue_instr(reg_instr(`OOO_OP_ADD, 3'd7, 3'd6, 3'd6));
		issue_instr(reg_instr(`OOO_OP_AND, 3'd1, 3'd7, 3'd3));
		wait_for_commits();
	endtask

	task automatic test_write_after_write();
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd2, 3'd0, 5'd1));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd2, 3'd2, 5'd2));
		issue_instr(reg_instr(`OOO_OP_ADD, 3'd3, 3'd2, 3'd2));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd2, 3'd3, 5'b11111));
		issue_instr(not_instr(3'd2, 3'd2));
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd4, 3'd2, 5'd4));
		issue_instr(reg_instr(`OOO_OP_ADD, 3'd2, 3'd4, 3'd3));
		issue_instr(imm_instr(`OOO_OP_AND, 3'd2, 3'd2, 5'd15));
		// Read back the final R2 once everything has retired
		wait_for_commits();
		issue_instr(imm_instr(`OOO_OP_ADD, 3'd5, 3'd2, 5'd0));
		wait_for_commits();
	endtask

	task automatic test_back_pressure();
		for (int i = 0; i < 40; i++)
			issue_instr(random_instr());
		wait_for_commits();
		// Idle window where any repeated retirement hits the empty queue
		repeat (`OOO_ROB_DEPTH) @(negedge clk);
	endtask

	initial
	begin
		#((TOTAL_INSTRS * 20 + 4 * RESET_CYCLES) * CLK_PERIOD);
		abort_run("Timeout: the tests did not finish in the allowed time");
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		commit_count = 0;
		seed = 39934;
		for (int i = 0; i < `OOO_NUM_REGS; i++)
			ref_regs[i] = '0;
		test_reset();
		test_immediate();
		test_dependencies();
		test_write_after_write();
		test_back_pressure();
		if (commit_count == TOTAL_INSTRS)
		begin
			$display("all tests passed");
			$finish;
		end
		else
			abort_run($sformatf("Only %0d of %0d instructions committed",
				commit_count, TOTAL_INSTRS));
	end

endmodule

//--- src.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/regfile.sv
rtl/reorder_buffer.sv
rtl/alu_rs_unit.sv
rtl/issue_control.sv
rtl/ooo_core.sv
tests/ooo_core_sva.sv
tests/ooo_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= ooo_core_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= tests failed
PASS_MSG ?= all tests passed
VFLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
